//--- rtl/music_pkg.sv
package music_pkg;

  localparam int song_depth = 128;
  localparam int song_addr_bits = $clog2(song_depth);

  localparam logic [11:0] reg_control = 12'h000;
  localparam logic [11:0] reg_sample_divider = 12'h004;
  localparam logic [11:0] reg_note_samples = 12'h008;
  localparam logic [11:0] reg_status = 12'h00c;
  localparam logic [11:0] song_base = 12'h200;   // word i sits at song_base + 4*i.

  localparam logic [3:0] rest_semitone = 4'd15;
  localparam logic [7:0] rest_level = 8'h80;     // mid scale, so a rest is silent.
  localparam logic [6:0] cmd_loop = 7'd0;        // any other opcode stops playback.

  localparam logic [1:0] seq_idle = 2'd0;
  localparam logic [1:0] seq_fetch = 2'd1;
  localparam logic [1:0] seq_decode = 2'd2;
  localparam logic [1:0] seq_play = 2'd3;

  // octave 0 steps, one equal-tempered semitone apart.
  // the largest entry shifted by octave 7 still fits in 16 bits.
  localparam logic [15:0] semitone_step [0:11] = '{
    16'd256, 16'd271, 16'd287, 16'd304,
    16'd323, 16'd342, 16'd362, 16'd384,
    16'd406, 16'd431, 16'd456, 16'd483
  };

  typedef union packed {
    struct packed {
      logic       is_command;
      logic [2:0] octave;
      logic [3:0] semitone;
    } note;
    struct packed {
      logic       is_command;
      logic [6:0] opcode;
    } command;
  } song_word_t;

  typedef enum logic {
    wave_square   = 1'b0,
    wave_sawtooth = 1'b1
  } waveform_t;

endpackage

//--- rtl/player_config_if.sv
interface player_config_if import music_pkg::*; ();

  logic          play_request;
  logic          start_pulse;     // one cycle wide, on a rising play bit.
  waveform_t     waveform;
  logic [15:0]   sample_divider;
  logic [15:0]   note_samples;
  logic          playing;

  modport control (
    output play_request, start_pulse, waveform, sample_divider, note_samples,
    input  playing
  );

  modport player (
    input  play_request, start_pulse, note_samples,
    output playing
  );

  modport tone (input playing, start_pulse, waveform, sample_divider);

endinterface

//--- rtl/song_bus_if.sv
interface song_bus_if import music_pkg::*; ();

  logic                      write_enable;
  logic [song_addr_bits-1:0] write_address;
  logic [7:0]                write_data;
  logic [song_addr_bits-1:0] read_address;
  logic [7:0]                read_data;   // valid one cycle after read_address.

  modport writer (
    output write_enable, write_address, write_data
  );

  modport reader (
    output read_address,
    input  read_data
  );

  modport memory (
    input  write_enable, write_address, write_data, read_address,
    output read_data
  );

endinterface

//--- rtl/apb_control.sv
module apb_control import music_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [11:0]               paddr,
  input  logic [31:0]               pwdata,
  input  logic [song_addr_bits-1:0] note_index,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  player_config_if.control          cfg,
  song_bus_if.writer                song
);

  logic        setup_phase;
  logic        apb_write;
  logic        song_hit;
  logic        reg_hit;
  logic        player_stopped;
  logic        play_idle;
  logic        playing_q;
  logic [31:0] read_value;

  assign setup_phase = psel && !penable;
  assign apb_write = psel && penable && pwrite;
  assign pready = 1'b1;

  // song words fill 0x200 to 0x3fc and must be word aligned.
  assign song_hit = (paddr[11:9] == song_base[11:9]) && (paddr[1:0] == 2'b00);

  assign song.write_enable = apb_write && song_hit;
  assign song.write_address = paddr[song_addr_bits+1:2];
  assign song.write_data = pwdata[7:0];

  // the sequencer dropped playing by itself after a stop command.
  assign player_stopped = playing_q && !cfg.playing;
  assign play_idle = !cfg.play_request || player_stopped;

  always_comb begin
    reg_hit = 1'b1;
    read_value = '0;
    case (paddr)
      reg_control:        read_value = {30'd0, logic'(cfg.waveform), cfg.play_request};
      reg_sample_divider: read_value = {16'd0, cfg.sample_divider};
      reg_note_samples:   read_value = {16'd0, cfg.note_samples};
      reg_status:         read_value = {17'd0, note_index, 7'd0, cfg.playing};
      default:            reg_hit = 1'b0;
    endcase
  end

  // read data and error are captured in the setup phase for the access phase.
  always_ff @(posedge clock) begin
    if (reset) begin
      prdata <= '0;
      pslverr <= 1'b0;
    end else if (setup_phase) begin
      prdata <= read_value;  // song memory is write only, so its reads return zero.
      pslverr <= !(reg_hit || song_hit);
    end else begin
      pslverr <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cfg.play_request <= 1'b0;
      cfg.start_pulse <= 1'b0;
      cfg.waveform <= wave_square;
      cfg.sample_divider <= '0;
      cfg.note_samples <= '0;
      playing_q <= 1'b0;
    end else begin
      cfg.start_pulse <= 1'b0;
      playing_q <= cfg.playing;
      if (player_stopped) begin
        cfg.play_request <= 1'b0;
      end
      if (apb_write) begin
        case (paddr)
          reg_control: begin
            cfg.play_request <= pwdata[0];
            cfg.waveform <= waveform_t'(pwdata[1]);
            cfg.start_pulse <= pwdata[0] && play_idle;
          end
          reg_sample_divider: cfg.sample_divider <= pwdata[15:0];
          reg_note_samples:   cfg.note_samples <= pwdata[15:0];
          default: ;
        endcase
      end
    end
  end

endmodule

//--- rtl/song_memory.sv
module song_memory import music_pkg::*; (
  input logic        clock,
  song_bus_if.memory song
);

  logic [7:0] mem [song_depth];

  // one write port for the host and one registered read port for the sequencer.
  always_ff @(posedge clock) begin
    if (song.write_enable) begin
      mem[song.write_address] <= song.write_data;
    end
    song.read_data <= mem[song.read_address];
  end

endmodule

//--- rtl/note_sequencer.sv
module note_sequencer import music_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  player_config_if.player           cfg,
  song_bus_if.reader                song,
  input  logic                      sample_strobe,
  output logic [15:0]               step,
  output logic                      rest,
  output logic                      new_note,
  output logic [song_addr_bits-1:0] note_index
);

  logic [1:0]  state;
  logic [15:0] sample_count;
  logic        last_sample;
  logic        note_is_rest;
  song_word_t  word;

  assign song.read_address = note_index;
  assign word = song.read_data;

  // semitones 12 to 14 have no pitch and play as rests.
  assign note_is_rest = (word.note.semitone == rest_semitone) ||
                        (word.note.semitone > 4'd11);

  assign last_sample = ({1'b0, sample_count} + 17'd1) >= {1'b0, cfg.note_samples};

  // a loop word costs one more fetch and decode, so it needs a divider of 5.
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= seq_idle;
      cfg.playing <= 1'b0;
      note_index <= '0;
      sample_count <= '0;
      step <= '0;
      rest <= 1'b0;
      new_note <= 1'b0;
    end else begin
      new_note <= 1'b0;
      if (cfg.start_pulse) begin
        state <= seq_fetch;
        cfg.playing <= 1'b1;
        note_index <= '0;
      end else if (!cfg.play_request) begin
        state <= seq_idle;
        cfg.playing <= 1'b0;
      end else begin
        case (state)
          seq_fetch: state <= seq_decode;  // memory latches the word here.
          seq_decode: begin
            if (!word.note.is_command) begin
              step <= note_is_rest ? 16'd0 :
                      semitone_step[word.note.semitone] << word.note.octave;
              rest <= note_is_rest;
              new_note <= 1'b1;
              sample_count <= '0;
              state <= seq_play;
            end else if (word.command.opcode == cmd_loop) begin
              note_index <= '0;
              state <= seq_fetch;
            end else begin
              state <= seq_idle;
              cfg.playing <= 1'b0;
            end
          end
          seq_play: begin
            if (sample_strobe) begin
              if (last_sample) begin
                sample_count <= '0;
                note_index <= note_index + 1'b1;  // wraps from 127 to 0.
                state <= seq_fetch;
              end else begin
                sample_count <= sample_count + 16'd1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- rtl/tone_generator.sv
module tone_generator import music_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  player_config_if.tone cfg,
  input  logic [15:0] step,
  input  logic        rest,
  input  logic        new_note,
  output logic        sample_strobe,
  output logic [7:0]  sample,
  output logic        sample_valid
);

  logic [15:0] divider_count;
  logic [15:0] phase;
  logic [7:0]  shaped;

  assign sample_strobe = cfg.playing && (divider_count >= cfg.sample_divider);

  // counts 0 to sample_divider, giving one strobe every divider plus one clocks.
  always_ff @(posedge clock) begin
    if (reset) begin
      divider_count <= '0;
    end else if (!cfg.playing || cfg.start_pulse || sample_strobe) begin
      divider_count <= '0;
    end else begin
      divider_count <= divider_count + 16'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || new_note) begin
      phase <= '0;
    end else if (sample_strobe) begin
      phase <= phase + step;
    end
  end

  // the sample is shaped from the phase before this strobe's step is added.
  always_comb begin
    if (rest) begin
      shaped = rest_level;
    end else if (cfg.waveform == wave_sawtooth) begin
      shaped = phase[15:8];
    end else begin
      shaped = phase[15] ? 8'hff : 8'h00;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sample <= '0;
    end else if (sample_strobe) begin
      sample <= shaped;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_strobe;  // high for one cycle with each new sample.
    end
  end

endmodule

//--- rtl/music_top.sv
module music_top import music_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic [7:0]  sample,
  output logic        sample_valid,
  output logic        playing
);

  logic [15:0]               step;
  logic                      rest;
  logic                      new_note;
  logic                      sample_strobe;
  logic [song_addr_bits-1:0] note_index;

  player_config_if cfg_bus ();
  song_bus_if      song_bus ();

  assign playing = cfg_bus.playing;

  apb_control u_apb_control (
    .clock      (clock),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .note_index (note_index),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .cfg        (cfg_bus.control),
    .song       (song_bus.writer)
  );

  song_memory u_song_memory (
    .clock (clock),
    .song  (song_bus.memory)
  );

  note_sequencer u_note_sequencer (
    .clock         (clock),
    .reset         (reset),
    .cfg           (cfg_bus.player),
    .song          (song_bus.reader),
    .sample_strobe (sample_strobe),
    .step          (step),
    .rest          (rest),
    .new_note      (new_note),
    .note_index    (note_index)
  );

  tone_generator u_tone_generator (
    .clock         (clock),
    .reset         (reset),
    .cfg           (cfg_bus.tone),
    .step          (step),
    .rest          (rest),
    .new_note      (new_note),
    .sample_strobe (sample_strobe),
    .sample        (sample),
    .sample_valid  (sample_valid)
  );

endmodule

//--- verification/music_properties.sv
module music_properties (
  input logic clock,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic sample_valid
);
  timeunit 1ns;
  timeprecision 1ns;

  int unsigned failures = 0;  // number of failed assertions so far.

  // every sample is announced by a pulse of a single cycle.
  valid_single_cycle: assert property (
    @(posedge clock) disable iff (reset) sample_valid |=> !sample_valid
  ) else begin
    failures++;
    $error("sample_valid was high on two cycles in a row.");
  end

  pready_high: assert property (@(posedge clock) disable iff (reset) pready)
    else begin
      failures++;
      $error("pready went low.");
    end

  pslverr_in_access: assert property (
    @(posedge clock) disable iff (reset) pslverr |-> (psel && penable)
  ) else begin
    failures++;
    $error("pslverr was raised outside an access phase.");
  end

endmodule

bind music_top music_properties u_properties (.*);

//--- verification/music_tb.sv
module music_tb import music_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  logic        clock = 1'b0;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  sample;
  logic        sample_valid;
  logic        playing;

  int unsigned divider = 7;       // keeps new_note ahead of the next strobe, even after a loop word.
  int unsigned note_len = 4;
  int unsigned wrap_notes = 130;  // enough notes to run past word 127 and wrap to word 0.
  int unsigned cycle_limit;
  int unsigned cycle_count = 0;
  logic [31:0] lfsr_state = 32'hcfa2d15f;
  logic [7:0]  song_words [song_depth];
  int          note_pos = -1;     // word of the note now playing, or -1 when no sample is due.
  int unsigned note_count = 0;
  int unsigned sample_total = 0;
  logic        wave_sel = 1'b0;

  music_top dut (.*);

  always #50 clock = ~clock;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);  // taps 32, 22, 2 and 1.
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    int          i;
    logic [31:0] bits;
    bits = '0;
    for (i = 0; i < count; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  // the phase before a strobe is the step times the strobes already played in the note.
  function automatic logic [7:0] expected_sample(input logic [7:0] word, input logic sawtooth,
                                                 input int unsigned count);
    logic [15:0] step;
    logic [15:0] phase;
    if (word[3:0] == rest_semitone) begin
      return rest_level;
    end
    step = semitone_step[word[3:0]] << word[6:4];
    phase = 16'(step * count);
    return sawtooth ? phase[15:8] : (phase[15] ? 8'hff : 8'h00);
  endfunction

  // follows loop words from a song position to the next note, or -1 at a stop word.
  function automatic int resolve_note(input int index);
    int pos;
    int hops;
    pos = index;
    for (hops = 0; hops < song_depth; hops++) begin
      if (!song_words[pos][7]) begin
        return pos;
      end
      if (song_words[pos][6:0] != 7'd0) begin
        return -1;
      end
      pos = 0;
    end
    return -1;
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      stop_with_error($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, want));
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    @(negedge clock);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic error);
    @(negedge clock);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clock);
    penable = 1'b1;
    data = prdata;    // both were registered in the setup phase.
    error = pslverr;
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_song_word(input int index, input logic [7:0] value);
    song_words[index] = value;
    apb_write(song_base + 12'(4 * index), {24'd0, value});
  endtask

  task automatic start_play(input logic sawtooth);
    wave_sel = sawtooth;
    note_count = 0;
    note_pos = resolve_note(0);
    apb_write(reg_control, {30'd0, sawtooth, 1'b1});
  endtask

  task automatic wait_samples(input int unsigned count);
    int unsigned target;
    target = sample_total + count;
    do @(posedge clock); while (sample_total < target);
  endtask

  // one sample may still follow the write, so the model stops only once playing is low.
  task automatic stop_play();
    apb_write(reg_control, 32'd0);
    while (playing) @(negedge clock);
    repeat (2) @(posedge clock);
    note_pos = -1;
    repeat (4 * (divider + 1)) @(posedge clock);
  endtask

  task automatic compare_sample();
    logic [7:0] want;
    assert (note_pos >= 0) else
      stop_with_error("A sample appeared after playback should have stopped.");
    if (note_pos >= 0) begin
      want = expected_sample(song_words[note_pos], wave_sel, note_count);
      assert (sample === want) else
        stop_with_error($sformatf("FAIL %0t: word %0d sample %0d is %h, expected %h",
                                  $time, note_pos, note_count, sample, want));
      sample_total++;
      note_count++;
      if (note_count == note_len) begin
        note_count = 0;
        note_pos = resolve_note((note_pos + 1) % song_depth);
      end
    end
  endtask

  always @(negedge clock) begin
    if (!reset && sample_valid) begin
      compare_sample();
    end
  end

  always @(negedge clock) begin
    if (dut.u_properties.failures != 0) begin
      stop_with_error("A bound assertion on the APB or audio outputs failed.");
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      stop_with_error("Timeout: the run took more cycles than the tests need.");
    end
  end

  initial begin
    logic [31:0] read_data;
    logic        read_error;
    logic [2:0]  octave;
    logic [3:0]  semitone;
    int unsigned run_start;
    int          i;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    // planned samples of all tests, plus room for APB traffic and quiet gaps.
    cycle_limit = ((2 * wrap_notes + 22) * note_len + 2) * (divider + 1) + 4000;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    apb_write(reg_sample_divider, divider);
    apb_write(reg_note_samples, note_len);
    apb_read(reg_sample_divider, read_data, read_error);
    check_value("sample divider", read_data, divider);
    apb_read(reg_note_samples, read_data, read_error);
    check_value("note length", read_data, note_len);
    check_value("pslverr on a mapped register", {31'd0, read_error}, 32'd0);
    apb_read(12'h010, read_data, read_error);
    check_value("pslverr on an unmapped address", {31'd0, read_error}, 32'd1);

    for (i = 0; i < song_depth; i++) begin
      octave = 3'(random_bits(3));
      semitone = 4'(random_bits(4));
      if (semitone > 4'd11) begin
        semitone = rest_semitone;
      end
      write_song_word(i, {1'b0, octave, semitone});
    end
    start_play(1'b0);
    wait_samples(wrap_notes * note_len);
    stop_play();
    start_play(1'b1);
    wait_samples(wrap_notes * note_len);
    stop_play();

    write_song_word(5, 8'h80);  // loop back to word 0.
    start_play(1'b0);
    wait_samples(7 * note_len);
    apb_read(reg_status, read_data, read_error);
    assert (read_data[0] && read_data[14:8] < 7'd5) else
      stop_with_error($sformatf("FAIL %0t: status %h during the loop", $time, read_data));
    check_value("playing output during the loop", {31'd0, playing}, 32'd1);
    wait_samples(5 * note_len);
    stop_play();

    write_song_word(3, 8'h81);  // stop after three notes.
    run_start = sample_total;
    start_play(1'b0);
    do @(negedge clock); while (!playing);
    while (playing) @(negedge clock);
    repeat (4 * (divider + 1)) @(posedge clock);
    check_value("samples before the stop word", sample_total - run_start, 3 * note_len);
    apb_read(reg_status, read_data, read_error);
    check_value("playing after the stop word", {31'd0, read_data[0]}, 32'd0);

    write_song_word(3, 8'h25);
    write_song_word(5, 8'h0f);
    start_play(1'b1);
    wait_samples(5 * note_len + 2);
    stop_play();
    apb_read(reg_status, read_data, read_error);
    check_value("playing after a host stop", {31'd0, read_data[0]}, 32'd0);
    start_play(1'b0);
    wait_samples(2 * note_len);
    stop_play();

    $display("No errors");
    $finish;
  end

endmodule

//--- tb.f
rtl/music_pkg.sv
rtl/player_config_if.sv
rtl/song_bus_if.sv
rtl/apb_control.sv
rtl/song_memory.sv
rtl/note_sequencer.sv
rtl/tone_generator.sv
rtl/music_top.sv
verification/music_properties.sv
verification/music_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= music_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
PASS_TEXT ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@output="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
